//--- source/loop_dispatch_defines.svh
`ifndef LOOP_DISPATCH_DEFINES_SVH
`define LOOP_DISPATCH_DEFINES_SVH

// Cores in the cluster, parent included
`define LD_N_CORE 4

// Iteration index and stride widths
`define LD_GC_WIDTH 32
`define LD_GD_WIDTH 16

`define LD_CNT_WIDTH 16

`endif

//--- source/loop_dispatch_pkg.sv
`default_nettype none

`include "loop_dispatch_defines.svh"

package loop_dispatch_pkg;

	// Iteration index, one full word
	typedef logic signed [`LD_GC_WIDTH-1:0] gc_t;

	// Stride, half a word, sign-extended before use
	typedef logic signed [`LD_GD_WIDTH-1:0] gd_t;

	// Grants handed out in the running section
	typedef logic [`LD_CNT_WIDTH-1:0] count_t;

	typedef enum logic {
		PH_IDLE,
		PH_PARALLEL
	} phase_t;

endpackage

`default_nettype wire

//--- source/fork_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module fork_control (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  issue_fork,
	input  logic [`LD_N_CORE-2:0] ending,
	output logic                  fork_load,
	output logic                  parallel,
	output logic                  done
);
	loop_dispatch_pkg::phase_t state;
	loop_dispatch_pkg::phase_t state_next;
	logic                      all_ending;

	// Section closes only once every child reports
	assign all_ending = &ending;

	// Forks while a section runs are dropped
	assign fork_load = issue_fork && (state == loop_dispatch_pkg::PH_IDLE);

	assign parallel = (state == loop_dispatch_pkg::PH_PARALLEL);

	always_comb begin
		state_next = state;
		case (state)
			loop_dispatch_pkg::PH_IDLE: begin
				if (issue_fork) begin
					state_next = loop_dispatch_pkg::PH_PARALLEL;
				end
			end
			loop_dispatch_pkg::PH_PARALLEL: begin
				if (all_ending) begin
					state_next = loop_dispatch_pkg::PH_IDLE;
				end
			end
			default: begin
				state_next = loop_dispatch_pkg::PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= loop_dispatch_pkg::PH_IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			// One pulse right after the closing edge
			done  <= parallel && all_ending;
		end
	end

	// Done follows a running section and never overlaps one
	assert property (@(posedge clk) disable iff (!arst_n)
		done |-> !parallel && $past(parallel))
	else $error("done pulse while the section is still running");

endmodule

`default_nettype wire

//--- source/index_allocator.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module index_allocator (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     fork_load,
	input  loop_dispatch_pkg::gc_t   fork_gc,
	input  loop_dispatch_pkg::gd_t   fork_gd,
	input  logic                     parallel,
	input  logic [`LD_N_CORE-1:0]    req,
	output logic [`LD_N_CORE-1:0]    take,
	output loop_dispatch_pkg::gc_t   next_index [`LD_N_CORE]
);
	// Rank runs from 0 up to the full core count
	localparam int RANK_W = $clog2(`LD_N_CORE + 1);

	loop_dispatch_pkg::gc_t gc;
	loop_dispatch_pkg::gd_t gd;
	loop_dispatch_pkg::gc_t gd_ext;

	// gc_plus[k] is gc advanced by k strides
	loop_dispatch_pkg::gc_t gc_plus [`LD_N_CORE+1];

	// rank[i] counts takers below core i, rank[N] is the total
	logic [RANK_W-1:0] rank [`LD_N_CORE+1];

	// Nothing is granted outside a section
	assign take = req & {`LD_N_CORE{parallel}};

	// Stride widened with its sign
	assign gd_ext = {{(`LD_GC_WIDTH-`LD_GD_WIDTH){gd[`LD_GD_WIDTH-1]}}, gd};

	always_comb begin
		gc_plus[0] = gc;
		for (int k = 0; k < `LD_N_CORE; k++) begin
			// Wraps in 32 bits
			gc_plus[k+1] = gc_plus[k] + gd_ext;
		end
	end

	// Prefix count of requesters in core order
	always_comb begin
		rank[0] = '0;
		for (int i = 0; i < `LD_N_CORE; i++) begin
			rank[i+1] = rank[i] + RANK_W'(take[i]);
		end
	end

	// Lower cores take the lower positions
	always_comb begin
		for (int i = 0; i < `LD_N_CORE; i++) begin
			next_index[i] = gc_plus[rank[i]];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gc <= '0;
			gd <= '0;
		end else if (fork_load) begin
			gc <= fork_gc;
			gd <= fork_gd;
		end else begin
			// Step past every index handed out this cycle
			gc <= gc_plus[rank[`LD_N_CORE]];
		end
	end

	// A fresh load must not race with grants from the old section
	assert property (@(posedge clk) disable iff (!arst_n)
		!(fork_load && (|take)))
	else $error("fork load coincides with granted requests");

endmodule

`default_nettype wire

//--- source/grant_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module grant_stage (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      fork_load,
	input  logic [`LD_N_CORE-1:0]     take,
	input  loop_dispatch_pkg::gc_t    next_index [`LD_N_CORE],
	output logic [`LD_N_CORE-1:0]     grant,
	output loop_dispatch_pkg::gc_t    index [`LD_N_CORE],
	output loop_dispatch_pkg::count_t issued
);
	loop_dispatch_pkg::count_t take_cnt;

	// Population count of this cycle's grants
	always_comb begin
		take_cnt = '0;
		for (int i = 0; i < `LD_N_CORE; i++) begin
			take_cnt = take_cnt + loop_dispatch_pkg::count_t'(take[i]);
		end
	end

	// Grants are pulses, one cycle after the request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant <= '0;
		end else begin
			grant <= take;
		end
	end

	// Each core keeps its last index until the next grant
	always_ff @(posedge clk) begin
		for (int i = 0; i < `LD_N_CORE; i++) begin
			if (take[i]) begin
				index[i] <= next_index[i];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issued <= '0;
		end else if (fork_load) begin
			// New section starts counting from zero
			issued <= '0;
		end else begin
			issued <= issued + take_cnt;
		end
	end

endmodule

`default_nettype wire

//--- source/loop_dispatch_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module loop_dispatch_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      issue_fork,
	input  loop_dispatch_pkg::gc_t    fork_gc,
	input  loop_dispatch_pkg::gd_t    fork_gd,
	input  logic [`LD_N_CORE-1:0]     req,
	input  logic [`LD_N_CORE-2:0]     ending,
	output logic                      parallel,
	output logic                      done,
	output logic [`LD_N_CORE-1:0]     grant,
	output loop_dispatch_pkg::gc_t    index [`LD_N_CORE],
	output loop_dispatch_pkg::count_t issued
);
	logic                   fork_load;
	logic [`LD_N_CORE-1:0]  take;
	loop_dispatch_pkg::gc_t next_index [`LD_N_CORE];

	// Section state, fork acceptance and end detection
	fork_control u_fork_control (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue_fork (issue_fork),
		.ending     (ending),
		.fork_load  (fork_load),
		.parallel   (parallel),
		.done       (done)
	);

	// Shared index, ranking and per-core positions
	index_allocator u_index_allocator (
		.clk        (clk),
		.arst_n     (arst_n),
		.fork_load  (fork_load),
		.fork_gc    (fork_gc),
		.fork_gd    (fork_gd),
		.parallel   (parallel),
		.req        (req),
		.take       (take),
		.next_index (next_index)
	);

	// Registered grants and the section grant count
	grant_stage u_grant_stage (
		.clk        (clk),
		.arst_n     (arst_n),
		.fork_load  (fork_load),
		.take       (take),
		.next_index (next_index),
		.grant      (grant),
		.index      (index),
		.issued     (issued)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

	// Reset held low for a fixed number of rising edges
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/loop_dispatch_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module loop_dispatch_checker (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      issue_fork,
	input  loop_dispatch_pkg::gc_t    fork_gc,
	input  loop_dispatch_pkg::gd_t    fork_gd,
	input  logic [`LD_N_CORE-1:0]     req,
	input  logic [`LD_N_CORE-2:0]     ending,
	input  logic                      parallel,
	input  logic                      done,
	input  logic [`LD_N_CORE-1:0]     grant,
	input  loop_dispatch_pkg::gc_t    index [`LD_N_CORE],
	input  loop_dispatch_pkg::count_t issued,
	output int                        errors
);
	loop_dispatch_pkg::phase_t m_phase;
	loop_dispatch_pkg::gc_t    m_gc;
	loop_dispatch_pkg::gd_t    m_gd;
	loop_dispatch_pkg::count_t m_count;
	logic [`LD_N_CORE-1:0]     exp_grant;
	logic                      exp_done;
	loop_dispatch_pkg::gc_t    exp_index [`LD_N_CORE];
	int                        err_count = 0;

	assign errors = err_count;

	task automatic report_mismatch(input string what);
		err_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, what);
	endtask

	// Reference model, stepped with the inputs seen at each edge
	always @(posedge clk or negedge arst_n) begin
		int k;
		loop_dispatch_pkg::gc_t step;
		if (!arst_n) begin
			m_phase = loop_dispatch_pkg::PH_IDLE;
			m_gc = '0;
			m_gd = '0;
			m_count = '0;
			exp_grant = '0;
			exp_done = 1'b0;
		end else begin
			exp_grant = '0;
			exp_done = 1'b0;
			if (m_phase == loop_dispatch_pkg::PH_PARALLEL) begin
				// Signed stride widened to a full index
				step = m_gd;
				k = 0;
				for (int i = 0; i < `LD_N_CORE; i++) begin
					if (req[i]) begin
						exp_grant[i] = 1'b1;
						exp_index[i] = m_gc + k * step;
						k++;
					end
				end
				m_gc = m_gc + k * step;
				m_count = m_count + loop_dispatch_pkg::count_t'(k);
				if (&ending) begin
					m_phase = loop_dispatch_pkg::PH_IDLE;
					exp_done = 1'b1;
				end
			end else if (issue_fork) begin
				m_phase = loop_dispatch_pkg::PH_PARALLEL;
				m_gc = fork_gc;
				m_gd = fork_gd;
				m_count = '0;
			end
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (arst_n === 1'b1) begin
			if (parallel !== (m_phase == loop_dispatch_pkg::PH_PARALLEL))
				report_mismatch($sformatf("parallel is %b, expected %b", parallel,
					m_phase == loop_dispatch_pkg::PH_PARALLEL));
			if (done !== exp_done)
				report_mismatch($sformatf("done is %b, expected %b", done, exp_done));
			if (grant !== exp_grant)
				report_mismatch($sformatf("grant is %b, expected %b", grant, exp_grant));
			if (issued !== m_count)
				report_mismatch($sformatf("issued is %0d, expected %0d", issued, m_count));
			for (int i = 0; i < `LD_N_CORE; i++) begin
				if (exp_grant[i] && index[i] !== exp_index[i])
					report_mismatch($sformatf("core %0d index is %0d, expected %0d",
						i, index[i], exp_index[i]));
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_loop_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "loop_dispatch_defines.svh"

module tb_loop_dispatch;
	localparam int RESET_LIMIT = 100;
	localparam int DRAIN_LIMIT = 50;

	typedef struct packed {
		logic                   issue;
		loop_dispatch_pkg::gc_t gc;
		loop_dispatch_pkg::gd_t gd;
		logic [`LD_N_CORE-1:0]  req;
		logic [`LD_N_CORE-2:0]  ending;
	} row_t;

	logic                      clk;
	logic                      arst_n;
	logic                      issue_fork;
	loop_dispatch_pkg::gc_t    fork_gc;
	loop_dispatch_pkg::gd_t    fork_gd;
	logic [`LD_N_CORE-1:0]     req;
	logic [`LD_N_CORE-2:0]     ending;
	logic                      parallel;
	logic                      done;
	logic [`LD_N_CORE-1:0]     grant;
	loop_dispatch_pkg::gc_t    index [`LD_N_CORE];
	loop_dispatch_pkg::count_t issued;
	int                        value_errors;
	int                        other_errors;
	row_t                      rows [$];

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(16)) u_clock_gen (.clk(clk), .arst_n(arst_n));

	loop_dispatch_top UUT (.*);

	loop_dispatch_checker u_checker (.*, .errors(value_errors));

	task automatic add_row(input logic issue, input loop_dispatch_pkg::gc_t gc,
		input loop_dispatch_pkg::gd_t gd, input logic [`LD_N_CORE-1:0] rq,
		input logic [`LD_N_CORE-2:0] end_bits);
		row_t r;
		r = {issue, gc, gd, rq, end_bits};
		rows.push_back(r);
	endtask

	// Random requests, with the top child held back so the section stays open
	task automatic add_random_rows(input int n);
		row_t r;
		logic [31:0] rnd;
		for (int i = 0; i < n; i++) begin
			rnd = $urandom;
			r = '0;
			r.req = rnd[`LD_N_CORE-1:0];
			r.ending = rnd[8 +: `LD_N_CORE-1];
			r.ending[`LD_N_CORE-2] = 1'b0;
			rows.push_back(r);
		end
	endtask

	task automatic build_table();
		// Requests before any fork
		add_row(1'b0, '0, '0, 4'b1111, 3'b000);
		add_row(1'b0, '0, '0, 4'b0101, 3'b111);
		// Start 100, stride 3, one requester at a time
		add_row(1'b1, 32'sd100, 16'sd3, 4'b0000, 3'b000);
		add_row(1'b0, '0, '0, 4'b0001, 3'b000);
		add_row(1'b0, '0, '0, 4'b0100, 3'b000);
		add_row(1'b0, '0, '0, 4'b0000, 3'b000);
		add_row(1'b0, '0, '0, 4'b0010, 3'b000);
		add_row(1'b0, '0, '0, 4'b1111, 3'b000);
		// Fork inside a running section
		add_row(1'b1, 32'sd7000, -16'sd9, 4'b0110, 3'b001);
		add_row(1'b0, '0, '0, 4'b1000, 3'b000);
		add_random_rows(8);
		// Closing cycle is still served, later requests are not
		add_row(1'b0, '0, '0, 4'b1010, 3'b111);
		add_row(1'b0, '0, '0, 4'b1111, 3'b111);
		add_row(1'b0, '0, '0, 4'b0011, 3'b000);
		// Restart with a negative stride
		add_row(1'b1, -32'sd20, -16'sd5, 4'b1111, 3'b000);
		add_random_rows(16);
		add_row(1'b0, '0, '0, 4'b1101, 3'b111);
		add_row(1'b0, '0, '0, 4'b0000, 3'b000);
	endtask

	task automatic apply_rows();
		foreach (rows[i]) begin
			@(posedge clk);
			issue_fork <= rows[i].issue;
			fork_gc <= rows[i].gc;
			fork_gd <= rows[i].gd;
			req <= rows[i].req;
			ending <= rows[i].ending;
		end
		@(posedge clk);
		issue_fork <= 1'b0;
		req <= '0;
		ending <= '0;
	endtask

	// Wait for a few quiet cycles so the last rows get checked
	task automatic drain();
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < 3 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (!parallel && !done && grant == '0)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 3) begin
			$display("Timeout: dispatcher did not go quiet after the last row");
			other_errors++;
		end
	endtask

	initial begin
		int cycles;
		void'($urandom(32'h17af));
		issue_fork = 1'b0;
		fork_gc = '0;
		fork_gd = '0;
		req = '0;
		ending = '0;
		other_errors = 0;
		build_table();
		cycles = 0;
		while (arst_n !== 1'b1 && cycles < RESET_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (arst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			other_errors++;
		end else begin
			apply_rows();
			drain();
		end
		$display("Error count: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/loop_dispatch_pkg.sv
source/fork_control.sv
source/index_allocator.sv
source/grant_stage.sv
source/loop_dispatch_top.sv
dv/tb_clock_gen.sv
dv/loop_dispatch_checker.sv
dv/tb_loop_dispatch.sv

//--- Bender.yml
package:
  name: loop_dispatch

sources:
  - include_dirs:
      - source
    files:
      - source/loop_dispatch_pkg.sv
      - source/fork_control.sv
      - source/index_allocator.sv
      - source/grant_stage.sv
      - source/loop_dispatch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clock_gen.sv
      - dv/loop_dispatch_checker.sv
      - dv/tb_loop_dispatch.sv
